// File: bmem_chk.sv
`default_nettype none

`include "bmem_consts.svh"

module bmem_chk #(
  parameter int N_CLIENTS = `BMEM_N_CLIENTS
) (
  input wire                                   clk,
  input wire                                   rst,
  input wire  [N_CLIENTS-1:0]                  c_valid,
  input wire  [N_CLIENTS-1:0]                  c_ready,
  input wire  [N_CLIENTS-1:0]                  c_last,
  input wire  bmem_pkg::strb_t [N_CLIENTS-1:0] c_wstrb,
  input wire                                   w_running,
  input wire  bmem_pkg::client_t               w_client,
  input wire                                   r_running,
  input wire  bmem_pkg::client_t               r_client
);
  timeunit 1ns;
  timeprecision 1ps;

  import bmem_pkg::*;

  int err_cnt = 0;  // Read by the testbench.

  logic [N_CLIENTS-1:0] wr_mask;
  logic [N_CLIENTS-1:0] rd_mask;
  logic                 wvalid;

  function automatic void flag_error(input string msg);
    $error("%s", msg);
    err_cnt++;
  endfunction

  always_comb begin
    for (int i = 0; i < N_CLIENTS; i++) begin
      wr_mask[i] = c_valid[i] && (|c_wstrb[i]);
      rd_mask[i] = c_valid[i] && !(|c_wstrb[i]);
    end
  end

  assign wvalid = w_running && c_valid[w_client];  // Same as the channel's wvalid.

  a_one_writer: assert property (@(posedge clk) disable iff (rst)
    $onehot0(c_ready & wr_mask))
    else flag_error("more than one writer sees ready");

  a_one_reader: assert property (@(posedge clk) disable iff (rst)
    $onehot0(c_ready & rd_mask))
    else flag_error("more than one reader sees ready");

  a_last_ready: assert property (@(posedge clk) disable iff (rst)
    (c_last & ~c_ready) == '0)
    else flag_error("last raised without ready");

  a_w_hold: assert property (@(posedge clk) disable iff (rst)
    w_running |=> (!w_running || w_client == $past(w_client)))
    else flag_error("write grant moved mid burst");

  a_r_hold: assert property (@(posedge clk) disable iff (rst)
    r_running |=> (!r_running || r_client == $past(r_client)))
    else flag_error("read grant moved mid burst");

  a_w_strb: assert property (@(posedge clk) disable iff (rst)
    wvalid |-> (|c_wstrb[w_client]))
    else flag_error("write beat with zero strobes");

endmodule

`default_nettype wire

// File: bmem_consts.svh
`ifndef BMEM_CONSTS_SVH
`define BMEM_CONSTS_SVH

// Word address width.
`define BMEM_ADDR_W 8

// Data path width, a whole number of bytes.
`define BMEM_DATA_W 32

// Burst length field. A burst carries len + 1 beats.
`define BMEM_LEN_W 4

// Clients sharing the memory.
`define BMEM_N_CLIENTS 2

// Memory words, one per address.
`define BMEM_DEPTH 256

`endif

// File: bmem_pkg.sv
`default_nettype none

`include "bmem_consts.svh"

package bmem_pkg;

  // Word address into the shared memory.
  typedef logic [`BMEM_ADDR_W-1:0] addr_t;

  // One data beat.
  typedef logic [`BMEM_DATA_W-1:0] word_t;

  // Byte enables. All zero marks a read burst.
  typedef logic [`BMEM_DATA_W/8-1:0] strb_t;

  // Beats minus one.
  typedef logic [`BMEM_LEN_W-1:0] len_t;

  // Client index.
  typedef logic [$clog2(`BMEM_N_CLIENTS)-1:0] client_t;

endpackage

`default_nettype wire

// File: bmem_tb.sv
`default_nettype none

`include "bmem_consts.svh"

module bmem_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import bmem_pkg::*;

  localparam int TOTAL_BEATS = 1328;  // Fill, solo, contention and final read-back.
  localparam int MAX_CYCLES  = 4 * TOTAL_BEATS + 200;
  localparam int REGION      = `BMEM_DEPTH / 2;

  logic                              clk;
  logic                              rst;
  logic  [`BMEM_N_CLIENTS-1:0]       c_valid;
  logic  [`BMEM_N_CLIENTS-1:0]       c_ready;
  logic  [`BMEM_N_CLIENTS-1:0]       c_last;
  addr_t [`BMEM_N_CLIENTS-1:0]       c_addr;
  word_t [`BMEM_N_CLIENTS-1:0]       c_wdata;
  strb_t [`BMEM_N_CLIENTS-1:0]       c_wstrb;
  len_t  [`BMEM_N_CLIENTS-1:0]       c_len;
  word_t                             c_rdata;

  logic [15:0] lfsr_q = 16'd51444;
  logic [7:0]  model_mem [0:`BMEM_DEPTH*4-1];  // Byte-level memory model.
  int          cycles = 0;

  bmem_top dut0 (
    .clk     (clk),
    .rst     (rst),
    .c_valid (c_valid),
    .c_ready (c_ready),
    .c_last  (c_last),
    .c_addr  (c_addr),
    .c_wdata (c_wdata),
    .c_wstrb (c_wstrb),
    .c_len   (c_len),
    .c_rdata (c_rdata)
  );

  bind burst_merge bmem_chk #(.N_CLIENTS(N_CLIENTS)) chk0 (
    .clk       (clk),
    .rst       (rst),
    .c_valid   (c_valid),
    .c_ready   (c_ready),
    .c_last    (c_last),
    .c_wstrb   (c_wstrb),
    .w_running (w_running),
    .w_client  (w_client),
    .r_running (r_running),
    .r_client  (r_client)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Run timed out after %0d cycles, a burst never completed", cycles);
      $display("Simulation FAILED");
      $fatal(1);
    end
  end

  // Taps 16, 14, 13, 11.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic word_t model_word(input int a);
    return {model_mem[a*4+3], model_mem[a*4+2], model_mem[a*4+1], model_mem[a*4]};
  endfunction

  task automatic check(input logic [31:0] exp, input logic [31:0] act, input string what);
    if (act !== exp) begin
      $display("** Error at %0d ns: %s, expected %h, got %h", $time, what, exp, act);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  // One burst on one client; checks last and read data per accepted beat.
  task automatic run_burst(input int cl, input addr_t base, input len_t len, input strb_t strb);
    int    beat;
    int    a;
    logic  took;
    word_t data;
    beat = 0;
    data = rand_bits(32);
    @(posedge clk);
    c_valid[cl] <= 1'b1;
    c_addr[cl]  <= base;
    c_len[cl]   <= len;
    c_wstrb[cl] <= strb;
    c_wdata[cl] <= data;
    while (beat <= int'(len)) begin
      @(negedge clk);
      took = c_ready[cl];
      if (took) begin
        check(32'(beat == int'(len)), 32'(c_last[cl]), "last on accepted beat");
        a = int'(base) + beat;
        if (strb != '0) begin
          for (int b = 0; b < 4; b++)
            if (strb[b]) model_mem[a*4+b] = data[8*b +: 8];
        end else begin
          check(model_word(a), c_rdata, "read data");
        end
        beat++;
      end else begin
        check(32'd0, 32'(c_last[cl]), "last without ready");
      end
      @(posedge clk);
      if (beat > int'(len)) begin
        c_valid[cl] <= 1'b0;
        c_wstrb[cl] <= '0;
      end else if (took) begin
        data = rand_bits(32);
        c_wdata[cl] <= data;
      end
    end
  endtask

  function automatic strb_t rand_strb();
    strb_t s;
    s = '0;
    while (s == '0)
      s = strb_t'(rand_bits(4));
    return s;
  endfunction

  function automatic addr_t rand_base(input int cl, input len_t len);
    return addr_t'(cl * REGION + int'(rand_bits(7)) % (REGION - int'(len)));
  endfunction

  task automatic sweep_region(input int cl, input logic wr);
    for (int k = 0; k < REGION / 16; k++)
      run_burst(cl, addr_t'(cl * REGION + 16 * k), len_t'(15), wr ? strb_t'(4'hf) : '0);
  endtask

  // Sixteen bursts covering every length, with idle gaps.
  task automatic mixed_bursts(input int cl, input logic wr);
    len_t len;
    for (int k = 0; k < 16; k++) begin
      len = len_t'(15 - k);
      run_burst(cl, rand_base(cl, len), len, wr ? rand_strb() : '0);
      repeat (int'(rand_bits(2))) @(posedge clk);
    end
  endtask

  initial begin
    addr_t bases [16];
    c_valid <= '0;
    c_addr  <= '0;
    c_wdata <= '0;
    c_wstrb <= '0;
    c_len   <= '0;
    rst     <= 1'b1;
    repeat (3) begin
      @(negedge clk);
      check(32'd0, 32'(c_ready), "ready during reset");
      check(32'd0, 32'(c_last), "last during reset");
    end
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check(32'd0, 32'(c_ready), "ready after reset");
    check(32'd0, 32'(c_last), "last after reset");

    // Both writers start together and fill their regions.
    fork
      sweep_region(0, 1'b1);
      sweep_region(1, 1'b1);
    join

    // Client 0 alone, every length, then read-back.
    for (int k = 0; k < 16; k++) begin
      bases[k] = rand_base(0, len_t'(k));
      run_burst(0, bases[k], len_t'(k), rand_strb());
    end
    for (int k = 0; k < 16; k++)
      run_burst(0, bases[k], len_t'(k), '0);

    // Write against read on the shared port.
    fork
      mixed_bursts(1, 1'b1);
      mixed_bursts(0, 1'b0);
    join
    fork
      mixed_bursts(0, 1'b1);
      mixed_bursts(1, 1'b0);
    join

    fork
      sweep_region(0, 1'b0);
      sweep_region(1, 1'b0);
    join

    if (dut0.merge0.chk0.err_cnt != 0) begin
      $display("Protocol assertions failed %0d times", dut0.merge0.chk0.err_cnt);
      $display("Simulation FAILED");
      $fatal(1);
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: bmem_top.sv
`default_nettype none

`include "bmem_consts.svh"

module bmem_top (
  input  wire                                          clk,
  input  wire                                          rst,
  input  wire  [`BMEM_N_CLIENTS-1:0]                   c_valid,
  output logic [`BMEM_N_CLIENTS-1:0]                   c_ready,
  output logic [`BMEM_N_CLIENTS-1:0]                   c_last,
  input  wire  bmem_pkg::addr_t [`BMEM_N_CLIENTS-1:0]  c_addr,
  input  wire  bmem_pkg::word_t [`BMEM_N_CLIENTS-1:0]  c_wdata,
  input  wire  bmem_pkg::strb_t [`BMEM_N_CLIENTS-1:0]  c_wstrb,
  input  wire  bmem_pkg::len_t  [`BMEM_N_CLIENTS-1:0]  c_len,
  output bmem_pkg::word_t                              c_rdata
);
  import bmem_pkg::*;

  // Write and read channels between the stages.
  burst_if bus0 ();

  burst_merge #(
    .N_CLIENTS (`BMEM_N_CLIENTS)
  ) merge0 (
    .clk     (clk),
    .rst     (rst),
    .c_valid (c_valid),
    .c_ready (c_ready),
    .c_last  (c_last),
    .c_addr  (c_addr),
    .c_wdata (c_wdata),
    .c_wstrb (c_wstrb),
    .c_len   (c_len),
    .c_rdata (c_rdata),
    .bus     (bus0)
  );

  burst_mem mem0 (
    .clk (clk),
    .rst (rst),
    .bus (bus0)
  );

endmodule

`default_nettype wire

// File: build.f
+incdir+.
bmem_pkg.sv
burst_if.sv
burst_merge.sv
burst_mem.sv
bmem_top.sv
bmem_chk.sv
bmem_tb.sv

// File: burst_if.sv
`default_nettype none

interface burst_if;
  import bmem_pkg::*;

  logic  wvalid;
  logic  wready;
  addr_t waddr;  // Burst base.
  word_t wdata;
  strb_t wstrb;
  len_t  wlen;
  logic  wlast;

  logic  rvalid;
  logic  rready;
  addr_t raddr;  // Burst base.
  len_t  rlen;
  logic  rlast;
  word_t rdata;

  modport merge (
    output wvalid, waddr, wdata, wstrb, wlen,
    input  wready, wlast,
    output rvalid, raddr, rlen,
    input  rready, rlast, rdata
  );

  modport mem (
    input  wvalid, waddr, wdata, wstrb, wlen,
    output wready, wlast,
    input  rvalid, raddr, rlen,
    output rready, rlast, rdata
  );

endinterface

`default_nettype wire

// File: burst_mem.sv
`default_nettype none

`include "bmem_consts.svh"

module burst_mem (
  input wire   clk,
  input wire   rst,
  burst_if.mem bus
);
  import bmem_pkg::*;

  localparam int BYTES = $bits(strb_t);

  word_t mem_q [`BMEM_DEPTH];

  len_t  w_cnt;    // Beats done in the write burst.
  len_t  r_cnt;    // Beats done in the read burst.
  logic  turn_rd;  // Set when reads own the port next.
  addr_t w_addr;
  addr_t r_addr;

  // One port, so only one channel moves per cycle.
  assign bus.wready = bus.wvalid && (!bus.rvalid || !turn_rd);
  assign bus.rready = bus.rvalid && (!bus.wvalid || turn_rd);

  assign bus.wlast = bus.wready && (w_cnt == bus.wlen);
  assign bus.rlast = bus.rready && (r_cnt == bus.rlen);

  assign w_addr = bus.waddr + addr_t'(w_cnt);
  assign r_addr = bus.raddr + addr_t'(r_cnt);

  assign bus.rdata = mem_q[r_addr];  // Asynchronous read.

  // Beat counters and port turn.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      w_cnt   <= '0;
      r_cnt   <= '0;
      turn_rd <= 1'b0;
    end else begin
      if (bus.wready) begin
        if (bus.wlast)
          w_cnt <= '0;
        else
          w_cnt <= w_cnt + 1'b1;
      end
      if (bus.rready) begin
        if (bus.rlast)
          r_cnt <= '0;
        else
          r_cnt <= r_cnt + 1'b1;
      end
      if (bus.wvalid && bus.rvalid)
        turn_rd <= !turn_rd;  // Alternate under contention.
    end
  end

  // Byte-strobed write.
  always_ff @(posedge clk) begin
    if (bus.wready) begin
      for (int b = 0; b < BYTES; b++) begin
        if (bus.wstrb[b])
          mem_q[w_addr][8*b +: 8] <= bus.wdata[8*b +: 8];
      end
    end
  end

endmodule

`default_nettype wire

// File: burst_merge.sv
`default_nettype none

`include "bmem_consts.svh"

module burst_merge #(
  parameter int N_CLIENTS = `BMEM_N_CLIENTS
) (
  input  wire                                   clk,
  input  wire                                   rst,
  input  wire  [N_CLIENTS-1:0]                  c_valid,
  output logic [N_CLIENTS-1:0]                  c_ready,
  output logic [N_CLIENTS-1:0]                  c_last,
  input  wire  bmem_pkg::addr_t [N_CLIENTS-1:0] c_addr,
  input  wire  bmem_pkg::word_t [N_CLIENTS-1:0] c_wdata,
  input  wire  bmem_pkg::strb_t [N_CLIENTS-1:0] c_wstrb,
  input  wire  bmem_pkg::len_t  [N_CLIENTS-1:0] c_len,
  output bmem_pkg::word_t                       c_rdata,
  burst_if.merge                                bus
);
  import bmem_pkg::*;

  logic    w_running;  // Write channel owned.
  client_t w_client;
  logic    r_running;  // Read channel owned.
  client_t r_client;

  logic    w_req_any;
  client_t w_req;
  logic    r_req_any;
  client_t r_req;

  logic    w_xfer;
  logic    r_xfer;

  // Sort requesters by strobes; the last hit in the loop is the highest index.
  always_comb begin
    w_req_any = 1'b0;
    w_req     = '0;
    r_req_any = 1'b0;
    r_req     = '0;
    for (int i = 0; i < N_CLIENTS; i++) begin
      if (c_valid[i]) begin
        if (|c_wstrb[i]) begin
          w_req_any = 1'b1;
          w_req     = client_t'(i);
        end else begin
          r_req_any = 1'b1;
          r_req     = client_t'(i);
        end
      end
    end
  end

  assign w_xfer = bus.wvalid && bus.wready;
  assign r_xfer = bus.rvalid && bus.rready;

  // Write channel grant.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      w_running <= 1'b0;
      w_client  <= '0;
    end else begin
      if (!w_running && w_req_any) begin
        w_running <= 1'b1;
        w_client  <= w_req;
      end
      if (w_running && w_xfer && bus.wlast)
        w_running <= 1'b0;  // Free on the last beat.
    end
  end

  // Read channel grant.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      r_running <= 1'b0;
      r_client  <= '0;
    end else begin
      if (!r_running && r_req_any) begin
        r_running <= 1'b1;
        r_client  <= r_req;
      end
      if (r_running && r_xfer && bus.rlast)
        r_running <= 1'b0;
    end
  end

  // Granted writer onto the write channel.
  always_comb begin
    bus.wvalid = 1'b0;
    bus.waddr  = '0;
    bus.wdata  = '0;
    bus.wstrb  = '0;
    bus.wlen   = '0;
    if (w_running) begin
      bus.wvalid = c_valid[w_client];
      bus.waddr  = c_addr[w_client];
      bus.wdata  = c_wdata[w_client];
      bus.wstrb  = c_wstrb[w_client];
      bus.wlen   = c_len[w_client];
    end
  end

  // Granted reader onto the read channel.
  always_comb begin
    bus.rvalid = 1'b0;
    bus.raddr  = '0;
    bus.rlen   = '0;
    if (r_running) begin
      bus.rvalid = c_valid[r_client];
      bus.raddr  = c_addr[r_client];
      bus.rlen   = c_len[r_client];
    end
  end

  // Handshake goes back to the owner of each channel only.
  always_comb begin
    c_ready = '0;
    c_last  = '0;
    if (w_running) begin
      c_ready[w_client] = bus.wready;
      c_last[w_client]  = bus.wlast;
    end
    if (r_running) begin
      c_ready[r_client] = c_ready[r_client] | bus.rready;
      c_last[r_client]  = c_last[r_client] | bus.rlast;
    end
  end

  assign c_rdata = bus.rdata;  // Shared by all clients.

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Compile and run the burst memory testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -f build.f --top-module bmem_tb \
  --Mdir obj_dir -o bmem_sim

# The log is searched below, so a failing run must not stop the script here.
./obj_dir/bmem_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
  exit 0
fi
echo "Run did not report a pass, see sim.log"
exit 1
